/* common/memOpPkg.sv */
package memOpPkg;

    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    // Loads in this range have side effects and must not run speculatively
    localparam logic [31:0] MMIO_BASE = 32'h1000_0000;
    localparam logic [31:0] MMIO_TOP = 32'h1000_FFFF;

    typedef logic [5:0] Tag;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        pipeCtrlPkg::SqN sqN;
        pipeCtrlPkg::SqN loadSqN;
        Tag tagDst;
        logic [31:0] pc;
        logic compressed;
        logic exception;
    } AguUop;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        pipeCtrlPkg::SqN sqN;
        pipeCtrlPkg::SqN loadSqN;
        Tag tagDst;
        logic isMmio;
    } LdUop;

    typedef struct packed {
        logic valid;
        logic fail;
        pipeCtrlPkg::SqN loadSqN;
    } LdAck;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        Tag tagDst;
        logic isMmio;
    } MemReq;

    typedef struct packed {
        logic valid;
        Tag tagDst;
        logic [31:0] data;
    } LdResult;

    // Two accesses collide only inside the same aligned word
    function automatic logic bytesOverlap(input logic [31:0] addrA, input logic [1:0] sizeA,
                                          input logic [31:0] addrB, input logic [1:0] sizeB);
        logic [3:0] maskA;
        logic [3:0] maskB;
        case (sizeA)
            SZ_BYTE: maskA = 4'b0001 << addrA[1:0];
            SZ_HALF: maskA = 4'b0011 << {addrA[1], 1'b0};
            default: maskA = 4'b1111;
        endcase
        case (sizeB)
            SZ_BYTE: maskB = 4'b0001 << addrB[1:0];
            SZ_HALF: maskB = 4'b0011 << {addrB[1], 1'b0};
            default: maskB = 4'b1111;
        endcase
        return (addrA[31:2] == addrB[31:2]) && ((maskA & maskB) != 4'b0000);
    endfunction

endpackage

/* common/pipeCtrlPkg.sv */
package pipeCtrlPkg;

    localparam int SQN_W = 7;
    localparam int LB_SIZE = 8;
    localparam int LB_IDX_W = $clog2(LB_SIZE);
    localparam int RETIRE_PER_CYCLE = 4;

    typedef logic [SQN_W-1:0] SqN;

    // Carries a taken branch into the unit and an ordering recovery out of it
    typedef struct packed {
        logic taken;
        logic flush;
        SqN sqN;
        SqN loadSqN;
        logic [31:0] dstPC;
    } BranchProv;

    // True when a comes before b in program order.
    // The sequence space wraps, so the sign of the difference decides
    function automatic logic isOlder(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return diff[SQN_W-1];
    endfunction

endpackage

/* hw/loadAligner.sv */
`timescale 1ns/1ps

module loadAligner (
    input  logic              clk,
    input  logic              rst,
    input  memOpPkg::MemReq   memReq,
    input  logic              memStall,
    input  logic [31:0]       memRdata,
    output memOpPkg::LdResult ldResult
);
    import memOpPkg::*;

    logic pending;
    logic [1:0] offset;
    logic [1:0] size;
    logic signExtend;
    Tag tagDst;
    logic [31:0] shifted;
    logic [31:0] aligned;

    // Memory answers one cycle after it accepts a request
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= memReq.valid && !memStall;
        end
        if (memReq.valid && !memStall) begin
            offset <= memReq.addr[1:0];
            size <= memReq.size;
            signExtend <= memReq.signExtend;
            tagDst <= memReq.tagDst;
        end
    end

    always_comb begin
        shifted = memRdata >> {offset, 3'b000};
        case (size)
            SZ_BYTE: aligned = {{24{signExtend & shifted[7]}}, shifted[7:0]};
            SZ_HALF: aligned = {{16{signExtend & shifted[15]}}, shifted[15:0]};
            default: aligned = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ldResult.valid <= 1'b0;
        end else begin
            ldResult.valid <= pending;
        end
        ldResult.tagDst <= tagDst;
        ldResult.data <= aligned;
    end

endmodule

/* hw/loadBuffer/loadBuffer.sv */
`timescale 1ns/1ps

module loadBuffer (
    input  logic                   clk,
    input  logic                   rst,
    input  memOpPkg::AguUop        loadIn,
    input  memOpPkg::AguUop        storeIn,
    input  pipeCtrlPkg::SqN        commitSqN,
    input  logic                   sqDone,
    input  logic                   issueStall,
    input  memOpPkg::LdAck         ldAck,
    input  pipeCtrlPkg::BranchProv branchIn,
    output memOpPkg::LdUop         directLoad,
    output memOpPkg::LdUop         lateLoad,
    output logic                   loadDelayed,
    output pipeCtrlPkg::BranchProv recovery,
    output pipeCtrlPkg::SqN        maxLoadSqN
);
    import memOpPkg::*;
    import pipeCtrlPkg::*;

    // The low loadSqN bits are the slot, so only the high bits are kept
    typedef struct packed {
        SqN sqN;
        Tag tagDst;
        logic [SQN_W-1:LB_IDX_W] highLdSqN;
        logic [1:0] size;
        logic [31:0] addr;
        logic signExtend;
        logic nonSpec;
        logic issued;
        logic valid;
    } LbEntry;

    LbEntry entries [LB_SIZE];

    SqN baseIndex;
    logic [LB_IDX_W-1:0] deqIndex;
    logic [LB_IDX_W-1:0] loadIdx;
    logic [LB_IDX_W-1:0] ackIdx;
    logic nonSpec;
    logic storeHazard;
    logic loadSquashed;
    logic storeSquashed;
    logic collision;
    logic issueLate;
    logic [$clog2(RETIRE_PER_CYCLE+1)-1:0] retireCount;

    function automatic logic inMmio(input logic [31:0] addr);
        return (addr >= MMIO_BASE) && (addr <= MMIO_TOP);
    endfunction

    assign deqIndex = baseIndex[LB_IDX_W-1:0];
    assign loadIdx = loadIn.loadSqN[LB_IDX_W-1:0];
    assign ackIdx = ldAck.loadSqN[LB_IDX_W-1:0];

    // Anything at or after a taken branch is on the wrong path
    assign loadSquashed = branchIn.taken && !isOlder(loadIn.sqN, branchIn.sqN);
    assign storeSquashed = branchIn.taken && !isOlder(storeIn.sqN, branchIn.sqN);

    always_comb begin
        nonSpec = loadIn.valid && inMmio(loadIn.addr) && !loadIn.exception;
        // An older store in the same cycle might need to forward, so hold the load
        storeHazard = loadIn.valid && storeIn.valid
            && !isOlder(loadIn.loadSqN, storeIn.loadSqN)
            && bytesOverlap(loadIn.addr, loadIn.size, storeIn.addr, storeIn.size);
        loadDelayed = nonSpec || storeHazard;

        directLoad.valid = loadIn.valid && !loadDelayed && !loadSquashed;
        directLoad.addr = loadIn.addr;
        directLoad.size = loadIn.size;
        directLoad.signExtend = loadIn.signExtend;
        directLoad.sqN = loadIn.sqN;
        directLoad.loadSqN = loadIn.loadSqN;
        directLoad.tagDst = loadIn.tagDst;
        directLoad.isMmio = inMmio(loadIn.addr);
    end

    // Any issued load younger than the store may have read stale data
    always_comb begin
        SqN entryLdSqN;
        collision = 1'b0;
        for (int i = 0; i < LB_SIZE; i++) begin
            entryLdSqN = {entries[i].highLdSqN, LB_IDX_W'(i)};
            if (entries[i].valid && entries[i].issued
                && !isOlder(entryLdSqN, storeIn.loadSqN)
                && bytesOverlap(entries[i].addr, entries[i].size, storeIn.addr, storeIn.size)) begin
                collision = 1'b1;
            end
        end
    end

    // Retire in order from the head and stop at the first entry that cannot go
    always_comb begin
        logic [LB_IDX_W-1:0] idx;
        logic chain;
        chain = 1'b1;
        retireCount = '0;
        for (int i = 0; i < RETIRE_PER_CYCLE; i++) begin
            idx = deqIndex + LB_IDX_W'(i);
            chain = chain && entries[idx].valid && entries[idx].issued
                && isOlder(entries[idx].sqN, commitSqN);
            if (chain) begin
                retireCount = retireCount + 1'b1;
            end
        end
    end

    // MMIO loads wait until they are the next instruction to commit and the store queue is empty
    assign issueLate = !branchIn.taken && (!lateLoad.valid || !issueStall)
        && entries[deqIndex].valid && !entries[deqIndex].issued
        && (!entries[deqIndex].nonSpec || (commitSqN == entries[deqIndex].sqN && sqDone));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
            baseIndex <= '0;
            maxLoadSqN <= SqN'(LB_SIZE - 1);
            lateLoad.valid <= 1'b0;
            recovery.taken <= 1'b0;
        end else begin
            // A rejected direct load goes back to waiting for late issue
            if (ldAck.valid && ldAck.fail && entries[ackIdx].valid) begin
                entries[ackIdx].issued <= 1'b0;
            end

            for (int i = 0; i < RETIRE_PER_CYCLE; i++) begin
                if (i < int'(retireCount)) begin
                    entries[deqIndex + LB_IDX_W'(i)].valid <= 1'b0;
                end
            end
            baseIndex <= baseIndex + SqN'(retireCount);
            maxLoadSqN <= baseIndex + SqN'(LB_SIZE - 1);

            if (!issueStall) begin
                lateLoad.valid <= 1'b0;
            end
            if (issueLate) begin
                lateLoad.valid <= 1'b1;
                lateLoad.addr <= entries[deqIndex].addr;
                lateLoad.size <= entries[deqIndex].size;
                lateLoad.signExtend <= entries[deqIndex].signExtend;
                lateLoad.sqN <= entries[deqIndex].sqN;
                lateLoad.loadSqN <= {entries[deqIndex].highLdSqN, deqIndex};
                lateLoad.tagDst <= entries[deqIndex].tagDst;
                lateLoad.isMmio <= inMmio(entries[deqIndex].addr);
                entries[deqIndex].issued <= 1'b1;
            end

            if (branchIn.taken) begin
                for (int i = 0; i < LB_SIZE; i++) begin
                    if (!isOlder(entries[i].sqN, branchIn.sqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
                if (lateLoad.valid && !isOlder(lateLoad.sqN, branchIn.sqN)) begin
                    lateLoad.valid <= 1'b0;
                end
                if (branchIn.flush) begin
                    baseIndex <= branchIn.loadSqN;
                end
            end

            if (loadIn.valid && !loadSquashed) begin
                entries[loadIdx] <= '{
                    sqN: loadIn.sqN,
                    tagDst: loadIn.tagDst,
                    highLdSqN: loadIn.loadSqN[SQN_W-1:LB_IDX_W],
                    size: loadIn.size,
                    addr: loadIn.addr,
                    signExtend: loadIn.signExtend,
                    nonSpec: nonSpec,
                    issued: !loadDelayed,
                    valid: 1'b1
                };
            end

            // Right after a recovery, a younger store is already being flushed
            recovery.taken <= storeIn.valid && !storeSquashed && collision
                && !(recovery.taken && !isOlder(storeIn.sqN, recovery.sqN));
        end

        // Refetch from the instruction after the store
        recovery.flush <= 1'b0;
        recovery.sqN <= storeIn.sqN;
        recovery.loadSqN <= storeIn.loadSqN;
        recovery.dstPC <= storeIn.pc + (storeIn.compressed ? 32'd2 : 32'd4);
    end

    // A direct load's ack comes one cycle after the load was written into its slot
    ackTargetsLiveEntry: assert property (@(posedge clk) disable iff (rst)
        ldAck.valid |-> entries[ackIdx].valid);

    // Back-to-back recoveries happen only when a strictly older store also hits
    recoveryIsPulse: assert property (@(posedge clk) disable iff (rst)
        recovery.taken |=> !recovery.taken || isOlder(recovery.sqN, $past(recovery.sqN)));

endmodule

/* hw/loadIssueArbiter.sv */
`timescale 1ns/1ps

module loadIssueArbiter (
    input  logic             clk,
    input  logic             rst,
    input  memOpPkg::LdUop   directLoad,
    input  memOpPkg::LdUop   lateLoad,
    input  logic             memStall,
    output logic             issueStall,
    output memOpPkg::LdAck   ldAck,
    output memOpPkg::MemReq  memReq
);
    import memOpPkg::*;

    LdUop winner;
    logic directRejected;

    // The late load stays in the buffer's register until the port frees up
    assign issueStall = memStall;

    always_comb begin
        winner = lateLoad.valid ? lateLoad : directLoad;
        directRejected = directLoad.valid && (memStall || lateLoad.valid);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memReq.valid <= 1'b0;
            ldAck.valid <= 1'b0;
        end else begin
            if (!memStall) begin
                memReq.valid <= winner.valid;
                memReq.addr <= winner.addr;
                memReq.size <= winner.size;
                memReq.signExtend <= winner.signExtend;
                memReq.tagDst <= winner.tagDst;
                memReq.isMmio <= winner.isMmio;
            end
            // Only direct loads are acked, since a late load never loses
            ldAck.valid <= directLoad.valid;
        end
        ldAck.fail <= directRejected;
        ldAck.loadSqN <= directLoad.loadSqN;
    end

    reqHeldUnderStall: assert property (@(posedge clk) disable iff (rst)
        memStall |=> $stable(memReq));

endmodule

/* hw/memOrderUnit.sv */
`timescale 1ns/1ps

module memOrderUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  memOpPkg::AguUop        loadIn,
    input  memOpPkg::AguUop        storeIn,
    input  pipeCtrlPkg::SqN        commitSqN,
    input  logic                   sqDone,
    input  pipeCtrlPkg::BranchProv branchIn,
    output pipeCtrlPkg::BranchProv recovery,
    output logic                   loadDelayed,
    output pipeCtrlPkg::SqN        maxLoadSqN,
    output memOpPkg::MemReq        memReq,
    input  logic                   memStall,
    input  logic [31:0]            memRdata,
    output memOpPkg::LdResult      ldResult
);
    import memOpPkg::*;

    LdUop directLoad;
    LdUop lateLoad;
    LdAck ldAck;
    logic issueStall;

    loadBuffer loadBufferInst (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .storeIn(storeIn),
        .commitSqN(commitSqN),
        .sqDone(sqDone),
        .issueStall(issueStall),
        .ldAck(ldAck),
        .branchIn(branchIn),
        .directLoad(directLoad),
        .lateLoad(lateLoad),
        .loadDelayed(loadDelayed),
        .recovery(recovery),
        .maxLoadSqN(maxLoadSqN)
    );

    loadIssueArbiter loadIssueArbiterInst (
        .clk(clk),
        .rst(rst),
        .directLoad(directLoad),
        .lateLoad(lateLoad),
        .memStall(memStall),
        .issueStall(issueStall),
        .ldAck(ldAck),
        .memReq(memReq)
    );

    loadAligner loadAlignerInst (
        .clk(clk),
        .rst(rst),
        .memReq(memReq),
        .memStall(memStall),
        .memRdata(memRdata),
        .ldResult(ldResult)
    );

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module memOrderUnitTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi
out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi
if echo "$out" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1

/* src.f */
common/pipeCtrlPkg.sv
common/memOpPkg.sv
hw/loadBuffer/loadBuffer.sv
hw/loadIssueArbiter.sv
hw/loadAligner.sv
hw/memOrderUnit.sv
test/memOrderChecker.sv
test/memOrderUnitTb.sv

/* test/memOrderChecker.sv */
`timescale 1ns/1ps

module memOrderChecker (
    input  logic                   clk,
    input  logic                   rst,
    input  memOpPkg::LdResult      ldResult,
    input  pipeCtrlPkg::BranchProv recovery,
    input  logic                   loadDelayed,
    input  logic                   loadValid,
    input  pipeCtrlPkg::SqN        maxLoadSqN,
    input  memOpPkg::MemReq        memReq,
    input  logic                   memStall
);
    import memOpPkg::*;
    import pipeCtrlPkg::*;

    logic [31:0] expData [64];
    bit expPending [64];
    SqN recSqNQ [$];
    logic [31:0] recPcQ [$];
    bit delayExp;
    logic expMmio;
    int checks;
    int errors;
    int missing;

    initial begin
        for (int i = 0; i < 64; i++) begin
            expPending[i] = 1'b0;
        end
        delayExp = 1'b0;
        checks = 0;
        errors = 0;
        missing = 0;
    end

    task automatic expectResult(input logic [5:0] tag, input logic [31:0] data);
        expData[tag] = data;
        expPending[tag] = 1'b1;
    endtask

    task automatic expectRecovery(input SqN sqN, input logic [31:0] pc);
        recSqNQ.push_back(sqN);
        recPcQ.push_back(pc);
    endtask

    task automatic expectDelayed(input bit delayed);
        delayExp = delayed;
    endtask

    // Registered output, so look at it away from the rising edge
    task automatic checkMaxLoadSqN(input SqN expected);
        @(negedge clk);
        checks++;
        if (maxLoadSqN !== expected) begin
            errors++;
            $display("FAIL t=%0t maxLoadSqN expected %h got %h", $time, expected, maxLoadSqN);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (loadValid) begin
                checks++;
                if (loadDelayed !== delayExp) begin
                    errors++;
                    $display("FAIL t=%0t loadDelayed expected %b got %b",
                             $time, delayExp, loadDelayed);
                end
            end
            // Every request that memory accepts must flag the MMIO region correctly
            if (memReq.valid && !memStall) begin
                checks++;
                expMmio = (memReq.addr >= MMIO_BASE) && (memReq.addr <= MMIO_TOP);
                if (memReq.isMmio !== expMmio) begin
                    errors++;
                    $display("FAIL t=%0t memReq.isMmio addr %h expected %b got %b",
                             $time, memReq.addr, expMmio, memReq.isMmio);
                end
            end
            // Results may come back in any order, so they are matched by tag
            if (ldResult.valid) begin
                checks++;
                if (!expPending[ldResult.tagDst]) begin
                    errors++;
                    $display("ERROR t=%0t: a load result arrived for tag %h, which was not expected",
                             $time, ldResult.tagDst);
                end else begin
                    expPending[ldResult.tagDst] = 1'b0;
                    if (ldResult.data !== expData[ldResult.tagDst]) begin
                        errors++;
                        $display("FAIL t=%0t ldResult.data tag %h expected %h got %h", $time,
                                 ldResult.tagDst, expData[ldResult.tagDst], ldResult.data);
                    end
                end
            end
            if (recovery.taken) begin
                checks++;
                if (recSqNQ.size() == 0) begin
                    errors++;
                    $display("ERROR t=%0t: a recovery was raised when none was expected", $time);
                end else begin
                    if (recovery.sqN !== recSqNQ[0]) begin
                        errors++;
                        $display("FAIL t=%0t recovery.sqN expected %h got %h",
                                 $time, recSqNQ[0], recovery.sqN);
                    end
                    if (recovery.dstPC !== recPcQ[0]) begin
                        errors++;
                        $display("FAIL t=%0t recovery.dstPC expected %h got %h",
                                 $time, recPcQ[0], recovery.dstPC);
                    end
                    void'(recSqNQ.pop_front());
                    void'(recPcQ.pop_front());
                end
            end
        end
    end

    task automatic finalReport(input int badRecords, output int totalErrors);
        for (int i = 0; i < 64; i++) begin
            if (expPending[i]) begin
                missing++;
                $display("ERROR: the load result for tag %h never arrived", i[5:0]);
            end
        end
        missing += recSqNQ.size();
        if (recSqNQ.size() != 0) begin
            $display("ERROR: %0d expected recoveries were never raised", recSqNQ.size());
        end
        totalErrors = errors + missing + badRecords;
        $display("Checks: %0d, mismatches: %0d, missing: %0d, bad records: %0d",
                 checks, errors, missing, badRecords);
    endtask

endmodule

/* test/memOrderUnitTb.sv */
`timescale 1ns/1ps

module memOrderUnitTb;
    import memOpPkg::*;
    import pipeCtrlPkg::*;

    logic clk;
    logic rst;
    AguUop loadIn;
    AguUop storeIn;
    SqN commitSqN;
    logic sqDone;
    BranchProv branchIn;
    BranchProv recovery;
    logic loadDelayed;
    SqN maxLoadSqN;
    MemReq memReq;
    logic memStall;
    logic [31:0] memRdata;
    LdResult ldResult;

    AguUop nextLoad;
    AguUop nextStore;
    BranchProv nextBranch;
    SqN nextCommit;
    logic nextSqDone;
    logic nextDelayed;
    bit stallMode;
    int seed;
    int recordCount;

    memOrderUnit memOrderUnit_i (
        .clk(clk), .rst(rst), .loadIn(loadIn), .storeIn(storeIn),
        .commitSqN(commitSqN), .sqDone(sqDone), .branchIn(branchIn),
        .recovery(recovery), .loadDelayed(loadDelayed), .maxLoadSqN(maxLoadSqN),
        .memReq(memReq), .memStall(memStall), .memRdata(memRdata), .ldResult(ldResult)
    );

    memOrderChecker chk (
        .clk(clk), .rst(rst), .ldResult(ldResult), .recovery(recovery),
        .loadDelayed(loadDelayed), .loadValid(loadIn.valid), .maxLoadSqN(maxLoadSqN),
        .memReq(memReq), .memStall(memStall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory contents follow the rule in the data file header
    function automatic logic [31:0] wordAt(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h80C0_4020;
    endfunction

    always @(posedge clk) begin
        if (memReq.valid && !memStall) begin
            memRdata <= wordAt(memReq.addr);
        end
    end

    task automatic runCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            loadIn <= nextLoad;
            storeIn <= nextStore;
            branchIn <= nextBranch;
            commitSqN <= nextCommit;
            sqDone <= nextSqDone;
            memStall <= stallMode ? (($random(seed) & 3) == 0) : 1'b0;
            // The checker samples loadDelayed later in the same cycle as this load
            chk.expectDelayed(nextDelayed);
            nextLoad = '0;
            nextStore = '0;
            nextBranch = '0;
            nextDelayed = 1'b0;
        end
    endtask

    initial begin
        wait (recordCount > 0);
        repeat (recordCount * 200) @(posedge clk);
        $display("Timeout: the test did not finish within %0d cycles", recordCount * 200);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int fd;
        int errs;
        int count;
        int badRecords;
        string op;
        string line;
        logic [31:0] f [7];
        loadIn = '0;
        storeIn = '0;
        branchIn = '0;
        commitSqN = '0;
        sqDone = 1'b0;
        memStall = 1'b0;
        memRdata = '0;
        rst = 1'b1;
        nextLoad = '0;
        nextStore = '0;
        nextBranch = '0;
        nextCommit = '0;
        nextSqDone = 1'b0;
        nextDelayed = 1'b0;
        stallMode = 1'b0;
        seed = 32'h52e6620d;
        count = 0;
        badRecords = 0;
        fd = $fopen("test/memOrder_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open test/memOrder_testdata.txt");
            $display(">>> FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    count++;
                end
            end
            $fclose(fd);
            recordCount = count + 10;
            fd = $fopen("test/memOrder_testdata.txt", "r");
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(line, fd));
                end else if (op == "L") begin
                    void'($fscanf(fd, "%h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6]));
                    nextLoad.valid = 1'b1;
                    nextLoad.tagDst = Tag'(f[0]);
                    nextLoad.sqN = SqN'(f[1]);
                    nextLoad.loadSqN = SqN'(f[2]);
                    nextLoad.addr = f[3];
                    nextLoad.size = f[4][1:0];
                    nextLoad.signExtend = f[5][0];
                    nextDelayed = f[6][0];
                end else if (op == "S") begin
                    void'($fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]));
                    nextStore.valid = 1'b1;
                    nextStore.sqN = SqN'(f[0]);
                    nextStore.loadSqN = SqN'(f[1]);
                    nextStore.addr = f[2];
                    nextStore.size = f[3][1:0];
                    nextStore.pc = f[4];
                    nextStore.compressed = f[5][0];
                end else if (op == "C") begin
                    void'($fscanf(fd, "%h %h", f[0], f[1]));
                    nextCommit = SqN'(f[0]);
                    nextSqDone = f[1][0];
                end else if (op == "B") begin
                    void'($fscanf(fd, "%h %h %h", f[0], f[1], f[2]));
                    nextBranch.taken = 1'b1;
                    nextBranch.sqN = SqN'(f[0]);
                    nextBranch.loadSqN = SqN'(f[1]);
                    nextBranch.flush = f[2][0];
                end else if (op == "T") begin
                    void'($fscanf(fd, "%h", f[0]));
                    stallMode = f[0][0];
                end else if (op == "W") begin
                    void'($fscanf(fd, "%h", f[0]));
                    runCycles(int'(f[0]));
                end else if (op == "E") begin
                    void'($fscanf(fd, "%h %h", f[0], f[1]));
                    chk.expectResult(f[0][5:0], f[1]);
                end else if (op == "R") begin
                    void'($fscanf(fd, "%h %h", f[0], f[1]));
                    chk.expectRecovery(SqN'(f[0]), f[1]);
                end else if (op == "X") begin
                    void'($fscanf(fd, "%h", f[0]));
                    chk.checkMaxLoadSqN(SqN'(f[0]));
                end else begin
                    badRecords++;
                    $display("Error: unknown record type %s in the data file", op);
                end
            end
            $fclose(fd);
            stallMode = 1'b0;
            runCycles(20);
            chk.finalReport(badRecords, errs);
            if (errs == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

/* test/memOrder_testdata.txt */
# L tag sqN loadSqN addr size sign delayed | S sqN loadSqN addr size pc compressed | C sqN done
# B sqN loadSqN flush | T stall | W cycles | E tag data | R sqN dstPC | X maxLoadSqN; mem = wordaddr ^ 80C04020
X 07
E 01 00000020
E 02 FFFFFFC0
E 03 000080C0
E 04 80C04120
L 01 01 00 00000100 0 1 0
W 1
L 02 02 01 00000102 0 1 0
W 1
L 03 03 02 00000102 1 0 0
W 1
L 04 04 03 00000100 2 0 0
W 1
T 1
E 05 00000080
E 06 00004220
L 05 05 04 00000203 0 0 0
W 1
L 06 06 05 00000200 1 1 0
W 10
C 07 1
W 30
T 0
W 10
X 0D
L 07 10 06 10000004 2 0 1
W 20
E 07 90C04024
C 10 1
W 10
C 11 1
W 5
E 08 80C04320
L 08 14 07 00000300 2 0 0
W 3
R 12 00001004
S 12 07 00000302 1 00001000 0
W 3
S 13 08 00000304 2 00002000 0
W 3
R 13 00002002
S 13 07 00000301 0 00002000 1
W 3
E 09 00000020
L 09 16 08 00000400 0 0 1
S 15 08 00000400 2 00003000 0
W 5
C 17 1
W 10
L 0A 20 09 10000008 2 0 1
W 5
B 1F 09 0
W 2
C 21 1
W 20
X 10
